// File: source/rv32_isa_pkg.sv
// RV32I encoding constants for the reduced integer core
// Only OP, OP-IMM, LUI and SYSTEM are recognized; any other opcode runs as a no-op
// Funct7 fields are reduced to the single alternate bit at position 30
`default_nettype none

package rv32_isa_pkg;

    // ==================================================
    // Basic field types
    // ==================================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Recognized opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct7 bit selecting SUB / SRA (instruction bit 30)
    localparam int F7_ALT_BIT = 5;

    // Sequential fetch step
    localparam word_t INSTR_BYTES = 32'd4;

    // ADDI x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

// File: source/core_pipe_pkg.sv
// Pipeline payload types for the three-stage core
// A payload of all zeros is a bubble: valid, reg_write and is_halt all low
`default_nettype none

package core_pipe_pkg;

    // ==================================================
    // ALU operation select
    // ==================================================
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // LUI, operand B straight through
    } alu_op_t;

    // IF/ID payload
    typedef struct packed {
        logic                valid;
        rv32_isa_pkg::word_t pc;
        rv32_isa_pkg::word_t instr;
    } fetch_payload_t;

    // ID/EX payload
    typedef struct packed {
        logic                    valid;
        logic                    reg_write;
        logic                    is_halt;
        alu_op_t                 alu_op;
        logic                    use_imm;
        rv32_isa_pkg::reg_addr_t rs1_addr;
        rv32_isa_pkg::reg_addr_t rs2_addr;
        rv32_isa_pkg::word_t     rs1_data;
        rv32_isa_pkg::word_t     rs2_data;
        rv32_isa_pkg::word_t     imm;
        rv32_isa_pkg::reg_addr_t rd;
    } decode_payload_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
// Program counter, sequential fetch only, no branch targets
// A halt in decode pulls the address back to the halt and freezes it until reset
// Assumes the valid instruction in decode was fetched from pc - 4
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter rv32_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                halt_seen_i,
    output rv32_isa_pkg::word_t instr_addr_o
);

    rv32_isa_pkg::word_t pc_q;
    logic                frozen_q;
    logic                halt_now;

    // Halt in decode and not yet frozen
    assign halt_now = halt_seen_i && !frozen_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q     <= RESET_PC;
            frozen_q <= 1'b0;
        end else if (!stall_i && !frozen_q) begin
            if (halt_now) begin
                // Step back onto the halt itself and stop
                pc_q     <= pc_q - rv32_isa_pkg::INSTR_BYTES;
                frozen_q <= 1'b1;
            end else begin
                pc_q <= pc_q + rv32_isa_pkg::INSTR_BYTES;
            end
        end
    end

    // Show the halt address already in the cycle the halt is decoded
    assign instr_addr_o = halt_now ? pc_q - rv32_isa_pkg::INSTR_BYTES : pc_q;

    // Word alignment holds for any legal RESET_PC
    a_pc_aligned : assert property (@(posedge clk_i) disable iff (rst_i)
        instr_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/decode_unit.sv
// Decode stage, purely combinational
// OP, OP-IMM and LUI write a register; everything else writes nothing
// Halt is SYSTEM with funct3 zero, other SYSTEM encodings are no-ops
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  core_pipe_pkg::fetch_payload_t  fetch_i,
    output rv32_isa_pkg::reg_addr_t        rs1_addr_o,
    output rv32_isa_pkg::reg_addr_t        rs2_addr_o,
    input  rv32_isa_pkg::word_t            rs1_data_i,
    input  rv32_isa_pkg::word_t            rs2_data_i,
    output core_pipe_pkg::decode_payload_t decode_o,
    output logic                           halt_seen_o
);

    localparam int ALT_POS = 25 + rv32_isa_pkg::F7_ALT_BIT;

    // ==================================================
    // Field extraction
    // ==================================================
    rv32_isa_pkg::opcode_t   opcode;
    rv32_isa_pkg::reg_addr_t rd;
    logic [2:0]              funct3;
    logic                    alt;
    logic                    is_op;
    logic                    is_op_imm;
    logic                    is_lui;
    logic                    is_halt;
    core_pipe_pkg::alu_op_t  alu_op;

    assign opcode     = fetch_i.instr[6:0];
    assign rd         = fetch_i.instr[11:7];
    assign funct3     = fetch_i.instr[14:12];
    assign rs1_addr_o = fetch_i.instr[19:15];
    assign rs2_addr_o = fetch_i.instr[24:20];
    assign alt        = fetch_i.instr[ALT_POS];

    // Opcode classes
    assign is_op     = opcode == rv32_isa_pkg::OPC_OP;
    assign is_op_imm = opcode == rv32_isa_pkg::OPC_OP_IMM;
    assign is_lui    = opcode == rv32_isa_pkg::OPC_LUI;
    assign is_halt   = fetch_i.valid && opcode == rv32_isa_pkg::OPC_SYSTEM &&
                       funct3 == 3'b000;

    // ALU operation from funct3 and alt bit
    always_comb begin
        case (funct3)
            rv32_isa_pkg::F3_ADD_SUB: begin
                // No SUBI, alt bit there is part of the immediate
                alu_op = (is_op && alt) ? core_pipe_pkg::ALU_SUB : core_pipe_pkg::ALU_ADD;
            end
            rv32_isa_pkg::F3_SLL:  alu_op = core_pipe_pkg::ALU_SLL;
            rv32_isa_pkg::F3_SLT:  alu_op = core_pipe_pkg::ALU_SLT;
            rv32_isa_pkg::F3_SLTU: alu_op = core_pipe_pkg::ALU_SLTU;
            rv32_isa_pkg::F3_XOR:  alu_op = core_pipe_pkg::ALU_XOR;
            rv32_isa_pkg::F3_SR: begin
                alu_op = alt ? core_pipe_pkg::ALU_SRA : core_pipe_pkg::ALU_SRL;
            end
            rv32_isa_pkg::F3_OR:   alu_op = core_pipe_pkg::ALU_OR;
            default:               alu_op = core_pipe_pkg::ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = core_pipe_pkg::ALU_PASS_B;
        end
    end

    // ==================================================
    // Payload assembly
    // ==================================================
    always_comb begin
        decode_o.valid     = fetch_i.valid;
        // Unknown opcode or rd = x0 means no write
        decode_o.reg_write = fetch_i.valid && (is_op || is_op_imm || is_lui) &&
                             rd != '0;
        decode_o.is_halt   = is_halt;
        decode_o.alu_op    = alu_op;
        decode_o.use_imm   = is_op_imm || is_lui;
        decode_o.rs1_addr  = rs1_addr_o;
        decode_o.rs2_addr  = rs2_addr_o;
        decode_o.rs1_data  = rs1_data_i;
        decode_o.rs2_data  = rs2_data_i;
        // U immediate for LUI, sign-extended I immediate otherwise
        decode_o.imm       = is_lui ? {fetch_i.instr[31:12], 12'b0}
                                    : {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
        decode_o.rd        = rd;
    end

    assign halt_seen_o = is_halt;

endmodule

`default_nettype wire

// File: source/register_file.sv
// 32 x 32-bit register file, asynchronous reads, one synchronous write
// No write-through: a read in the write cycle returns the old value
// x0 is never written, so it reads zero after reset
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv32_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv32_isa_pkg::reg_addr_t rs2_addr_i,
    input  rv32_isa_pkg::reg_addr_t dbg_addr_i,
    input  logic                    we_i,
    input  rv32_isa_pkg::reg_addr_t waddr_i,
    input  rv32_isa_pkg::word_t     wdata_i,
    output rv32_isa_pkg::word_t     rs1_data_o,
    output rv32_isa_pkg::word_t     rs2_data_o,
    output rv32_isa_pkg::word_t     dbg_data_o
);

    rv32_isa_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Operand ports plus debug port
    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];
    assign dbg_data_o = regs_q[dbg_addr_i];

    // Decode must already have dropped x0 writes
    a_no_x0_write : assert property (@(posedge clk_i) disable iff (rst_i)
        we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

// File: source/pipeline_register.sv
// Generic stage register for a packed payload struct
// Stall wins over flush; flush and reset load the all-zero bubble
`timescale 1ns/1ns
`default_nettype none

module pipeline_register #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            q <= '0;
        end else if (!stall_i) begin
            // Bubble on flush, else take the new stage contents
            if (flush_i) begin
                q <= '0;
            end else begin
                q <= d_i;
            end
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

// File: source/execute_unit.sv
// Execute and writeback stage
// Single forwarding source: the last valid register write, held in a local copy
// Write request is combinational and dropped while stalled
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           stall_i,
    input  core_pipe_pkg::decode_payload_t decode_i,
    output logic                           we_o,
    output rv32_isa_pkg::reg_addr_t        waddr_o,
    output rv32_isa_pkg::word_t            wdata_o,
    output logic                           halted_o
);

    rv32_isa_pkg::reg_addr_t fwd_rd_q;
    rv32_isa_pkg::word_t     fwd_data_q;
    rv32_isa_pkg::word_t     op_a;
    rv32_isa_pkg::word_t     op_b_reg;
    rv32_isa_pkg::word_t     op_b;
    rv32_isa_pkg::word_t     result;
    logic [4:0]              shamt;
    logic                    commit;
    logic                    halted_q;

    // ==================================================
    // Operand select
    // ==================================================
    // fwd_rd_q stays x0 until the first write, x0 never forwards
    assign op_a = (fwd_rd_q != '0 && fwd_rd_q == decode_i.rs1_addr) ? fwd_data_q
                                                                     : decode_i.rs1_data;
    assign op_b_reg = (fwd_rd_q != '0 && fwd_rd_q == decode_i.rs2_addr) ? fwd_data_q
                                                                         : decode_i.rs2_data;
    assign op_b  = decode_i.use_imm ? decode_i.imm : op_b_reg;
    assign shamt = op_b[4:0];

    // ALU
    always_comb begin
        case (decode_i.alu_op)
            core_pipe_pkg::ALU_ADD:  result = op_a + op_b;
            core_pipe_pkg::ALU_SUB:  result = op_a - op_b;
            core_pipe_pkg::ALU_SLL:  result = op_a << shamt;
            core_pipe_pkg::ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pipe_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
            core_pipe_pkg::ALU_XOR:  result = op_a ^ op_b;
            core_pipe_pkg::ALU_SRL:  result = op_a >> shamt;
            core_pipe_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
            core_pipe_pkg::ALU_OR:   result = op_a | op_b;
            core_pipe_pkg::ALU_AND:  result = op_a & op_b;
            default:                 result = op_b;
        endcase
    end

    // ==================================================
    // Writeback and forwarding copy
    // ==================================================
    assign commit  = decode_i.valid && decode_i.reg_write && !stall_i;
    assign we_o    = commit;
    assign waddr_o = decode_i.rd;
    assign wdata_o = result;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fwd_rd_q <= '0;
            halted_q <= 1'b0;
        end else if (!stall_i) begin
            if (commit) begin
                fwd_rd_q <= decode_i.rd;
            end
            // Sticky until reset
            if (decode_i.valid && decode_i.is_halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (commit) begin
            fwd_data_q <= result;
        end
    end

    assign halted_o = halted_q;

    // Once halted, only reset brings the core back
    a_halt_sticky : assert property (@(posedge clk_i) disable iff (rst_i)
        halted_o |=> halted_o);

endmodule

`default_nettype wire

// File: source/rv32_core.sv
// Three-stage RV32I subset core: fetch, decode, execute with writeback
// stall_i freezes the PC, both stage registers, the forwarding copy and writes
// Instruction memory is read combinationally in the same cycle as instr_addr_o
`timescale 1ns/1ns
`default_nettype none

module rv32_core #(
    parameter rv32_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stall_i,
    output rv32_isa_pkg::word_t     instr_addr_o,
    input  rv32_isa_pkg::word_t     instr_data_i,
    input  rv32_isa_pkg::reg_addr_t dbg_addr_i,
    output rv32_isa_pkg::word_t     dbg_data_o,
    output logic                    halted_o
);

    core_pipe_pkg::fetch_payload_t  fetch_d;
    core_pipe_pkg::fetch_payload_t  if_id_q;
    core_pipe_pkg::decode_payload_t decode_d;
    core_pipe_pkg::decode_payload_t id_ex_q;
    rv32_isa_pkg::reg_addr_t        rs1_addr;
    rv32_isa_pkg::reg_addr_t        rs2_addr;
    rv32_isa_pkg::word_t            rs1_data;
    rv32_isa_pkg::word_t            rs2_data;
    rv32_isa_pkg::reg_addr_t        waddr;
    rv32_isa_pkg::word_t            wdata;
    logic                           we;
    logic                           halt_seen;
    logic                           fetch_valid;

    // ==================================================
    // Fetch
    // ==================================================
    fetch_unit #(.RESET_PC(RESET_PC)) fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .halt_seen_i  (halt_seen),
        .instr_addr_o (instr_addr_o)
    );

    // No new work once the halt has left decode
    assign fetch_valid = !(halted_o || (id_ex_q.valid && id_ex_q.is_halt));
    assign fetch_d     = '{valid: fetch_valid, pc: instr_addr_o, instr: instr_data_i};

    pipeline_register #(.payload_t(core_pipe_pkg::fetch_payload_t)) if_id_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (halt_seen),
        .d_i     (fetch_d),
        .q_o     (if_id_q)
    );

    // ==================================================
    // Decode
    // ==================================================
    decode_unit decode (
        .fetch_i     (if_id_q),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .decode_o    (decode_d),
        .halt_seen_o (halt_seen)
    );

    register_file regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .dbg_addr_i (dbg_addr_i),
        .we_i       (we),
        .waddr_i    (waddr),
        .wdata_i    (wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_data_o)
    );

    pipeline_register #(.payload_t(core_pipe_pkg::decode_payload_t)) id_ex_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (1'b0),
        .d_i     (decode_d),
        .q_o     (id_ex_q)
    );

    // ==================================================
    // Execute and writeback
    // ==================================================
    execute_unit execute (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .decode_i (id_ex_q),
        .we_o     (we),
        .waddr_o  (waddr),
        .wdata_o  (wdata),
        .halted_o (halted_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_rv32_core.sv
// Directed tests for the three-stage core, ROM model fed combinationally from instr_addr_o
// Programs are straight-line code ending in halt; the ROM answers NOP beyond the program
// RESET_PC is left at zero, and programs stay within 64 words
`timescale 1ns/1ns
`default_nettype none

module tb_rv32_core;

    localparam int RUN_LIMIT = 400;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    rv32_isa_pkg::word_t     instr_addr;
    rv32_isa_pkg::word_t     instr_data;
    rv32_isa_pkg::reg_addr_t dbg_addr;
    rv32_isa_pkg::word_t     dbg_data;
    logic                    halted;

    // Program image and shadow registers
    rv32_isa_pkg::word_t rom [64];
    rv32_isa_pkg::word_t shadow [32];
    rv32_isa_pkg::word_t halt_addr;
    int                  prog_len;
    logic                past_halt;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;

    rv32_core #(.RESET_PC(32'h0)) uut (
        .clk_i        (clk),
        .rst_i        (rst),
        .stall_i      (stall),
        .instr_addr_o (instr_addr),
        .instr_data_i (instr_data),
        .dbg_addr_i   (dbg_addr),
        .dbg_data_o   (dbg_data),
        .halted_o     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction ROM, same-cycle read
    always_comb begin
        if ((instr_addr >> 2) < rv32_isa_pkg::word_t'(prog_len)) begin
            instr_data = rom[instr_addr[7:2]];
        end else begin
            instr_data = rv32_isa_pkg::NOP_WORD;
        end
    end

    // ==================================================
    // Encoders and reference rules
    // ==================================================
    function automatic rv32_isa_pkg::word_t r_word(input logic alt, input logic [2:0] f3,
        input rv32_isa_pkg::reg_addr_t rd, input rv32_isa_pkg::reg_addr_t rs1,
        input rv32_isa_pkg::reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv32_isa_pkg::OPC_OP};
    endfunction

    function automatic rv32_isa_pkg::word_t i_word(input logic [2:0] f3,
        input rv32_isa_pkg::reg_addr_t rd, input rv32_isa_pkg::reg_addr_t rs1,
        input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv32_isa_pkg::OPC_OP_IMM};
    endfunction

    // RV32I semantics, shifts use the low five bits
    function automatic rv32_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
        input rv32_isa_pkg::word_t a, input rv32_isa_pkg::word_t b);
        case (f3)
            rv32_isa_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
            rv32_isa_pkg::F3_SLL:     return a << b[4:0];
            rv32_isa_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32_isa_pkg::F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            rv32_isa_pkg::F3_XOR:     return a ^ b;
            rv32_isa_pkg::F3_SR: begin
                return alt ? rv32_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            end
            rv32_isa_pkg::F3_OR:      return a | b;
            default:                  return a & b;
        endcase
    endfunction

    task automatic new_program();
        prog_len  = 0;
        past_halt = 1'b0;
        halt_addr = 32'hFFFF_FFFC;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
    endtask

    // Append a word, nothing retires
    task automatic raw_word(input rv32_isa_pkg::word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic reg_op(input logic alt, input logic [2:0] f3,
        input rv32_isa_pkg::reg_addr_t rd, input rv32_isa_pkg::reg_addr_t rs1,
        input rv32_isa_pkg::reg_addr_t rs2);
        raw_word(r_word(alt, f3, rd, rs1, rs2));
        if (!past_halt && rd != 5'd0) begin
            shadow[rd] = alu_ref(f3, alt, shadow[rs1], shadow[rs2]);
        end
    endtask

    task automatic imm_op(input logic [2:0] f3, input rv32_isa_pkg::reg_addr_t rd,
        input rv32_isa_pkg::reg_addr_t rs1, input logic [11:0] imm);
        logic alt;
        alt = (f3 == rv32_isa_pkg::F3_SR) && imm[10];
        raw_word(i_word(f3, rd, rs1, imm));
        if (!past_halt && rd != 5'd0) begin
            shadow[rd] = alu_ref(f3, alt, shadow[rs1], {{20{imm[11]}}, imm});
        end
    endtask

    task automatic upper_imm(input rv32_isa_pkg::reg_addr_t rd, input logic [19:0] imm);
        raw_word({imm, rd, rv32_isa_pkg::OPC_LUI});
        if (!past_halt && rd != 5'd0) begin
            shadow[rd] = {imm, 12'b0};
        end
    endtask

    task automatic halt_instr();
        halt_addr = rv32_isa_pkg::word_t'(prog_len) << 2;
        past_halt = 1'b1;
        raw_word({25'b0, rv32_isa_pkg::OPC_SYSTEM});
    endtask

    // ==================================================
    // Compare tasks and run control
    // ==================================================
    task automatic check_word(input string name, input rv32_isa_pkg::word_t exp,
        input rv32_isa_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // Reset held for four rising edges
    task automatic reset_core();
        @(posedge clk);
        rst      <= 1'b1;
        stall    <= 1'b0;
        dbg_addr <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Reset, then run until halted_o with a timeout
    task automatic run_program(input logic with_stall);
        int                  cyc;
        int                  addr_cyc;
        logic                done;
        logic                prev_stall;
        rv32_isa_pkg::word_t prev_addr;
        rv32_isa_pkg::word_t r;
        reset_core();
        cyc        = 0;
        addr_cyc   = -1;
        done       = 1'b0;
        prev_stall = 1'b0;
        prev_addr  = '0;
        while (!done && cyc < RUN_LIMIT) begin
            @(negedge clk);
            if (cyc == 0) begin
                check_flag("halted_o", 1'b0, halted);
            end
            // A stalled edge leaves the fetch address alone
            if (prev_stall) begin
                check_word("instr_addr_o", prev_addr, instr_addr);
            end
            if (addr_cyc < 0 && instr_addr == halt_addr) begin
                addr_cyc = cyc;
            end
            if (halted) begin
                done = 1'b1;
                if (!with_stall && cyc - addr_cyc != 3) begin
                    errors++;
                    $display("halted_o rose %0d cycles after the halt address, expected 3",
                             cyc - addr_cyc);
                end
            end
            prev_stall = stall;
            prev_addr  = instr_addr;
            cyc++;
            @(posedge clk);
            r = $urandom;
            stall <= with_stall && !done && r[0];
        end
        if (!done) begin
            errors++;
            $display("Timeout: halted_o stayed low for %0d cycles", RUN_LIMIT);
        end
        stall <= 1'b0;
    endtask

    // All 32 registers through the debug port
    task automatic compare_regs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_addr <= rv32_isa_pkg::reg_addr_t'(i);
            @(negedge clk);
            check_word($sformatf("dbg_data_o[x%0d]", i), shadow[i], dbg_data);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL, %0d errors", name, errors - errs_before);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic r_type_ops();
        int e;
        e = errors;
        new_program();
        upper_imm(5'd2, 20'h12345);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd2, 5'd2, 12'h678);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'hFF9);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'h005);
        upper_imm(5'd4, 20'h80000);
        reg_op(1'b0, rv32_isa_pkg::F3_ADD_SUB, 5'd5, 5'd1, 5'd2);
        reg_op(1'b1, rv32_isa_pkg::F3_ADD_SUB, 5'd6, 5'd1, 5'd2);
        reg_op(1'b0, rv32_isa_pkg::F3_AND, 5'd7, 5'd1, 5'd2);
        reg_op(1'b0, rv32_isa_pkg::F3_OR, 5'd8, 5'd1, 5'd2);
        reg_op(1'b0, rv32_isa_pkg::F3_XOR, 5'd9, 5'd1, 5'd2);
        reg_op(1'b0, rv32_isa_pkg::F3_SLT, 5'd10, 5'd1, 5'd3);
        reg_op(1'b0, rv32_isa_pkg::F3_SLTU, 5'd11, 5'd1, 5'd3);
        reg_op(1'b0, rv32_isa_pkg::F3_SLL, 5'd12, 5'd2, 5'd3);
        reg_op(1'b0, rv32_isa_pkg::F3_SR, 5'd13, 5'd4, 5'd3);
        reg_op(1'b1, rv32_isa_pkg::F3_SR, 5'd14, 5'd4, 5'd3);
        reg_op(1'b1, rv32_isa_pkg::F3_ADD_SUB, 5'd15, 5'd3, 5'd1);
        reg_op(1'b0, rv32_isa_pkg::F3_SLT, 5'd16, 5'd3, 5'd1);
        reg_op(1'b0, rv32_isa_pkg::F3_SLTU, 5'd17, 5'd3, 5'd1);
        // MISC-MEM and a CSR-style SYSTEM word, both no-ops
        raw_word(32'h0000_0A0F);
        raw_word(32'h0000_1AF3);
        halt_instr();
        run_program(1'b0);
        compare_regs();
        report_test("r_type_ops", e);
    endtask

    task automatic imm_forms();
        int e;
        e = errors;
        new_program();
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'hFFF);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd2, 5'd1, 12'h800);
        imm_op(rv32_isa_pkg::F3_SLT, 5'd3, 5'd1, 12'h000);
        imm_op(rv32_isa_pkg::F3_SLTU, 5'd4, 5'd0, 12'hFFF);
        imm_op(rv32_isa_pkg::F3_XOR, 5'd5, 5'd2, 12'hFFF);
        imm_op(rv32_isa_pkg::F3_OR, 5'd6, 5'd0, 12'h7FF);
        imm_op(rv32_isa_pkg::F3_AND, 5'd7, 5'd1, 12'h0F0);
        imm_op(rv32_isa_pkg::F3_SLL, 5'd8, 5'd1, 12'h01F);
        imm_op(rv32_isa_pkg::F3_SR, 5'd9, 5'd1, 12'h004);
        imm_op(rv32_isa_pkg::F3_SR, 5'd10, 5'd2, 12'h403);
        upper_imm(5'd11, 20'hABCDE);
        upper_imm(5'd12, 20'hFFFFF);
        // x0 stays zero whatever targets it
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'h005);
        upper_imm(5'd0, 20'h12345);
        reg_op(1'b0, rv32_isa_pkg::F3_OR, 5'd0, 5'd1, 5'd2);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd13, 5'd0, 12'h001);
        halt_instr();
        run_program(1'b0);
        compare_regs();
        report_test("imm_forms", e);
    endtask

    // Each step reads the result of the step before
    task automatic forwarding_chain();
        int e;
        e = errors;
        new_program();
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h003);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd2, 5'd1, 12'hFFB);
        reg_op(1'b1, rv32_isa_pkg::F3_ADD_SUB, 5'd3, 5'd2, 5'd1);
        imm_op(rv32_isa_pkg::F3_SLL, 5'd4, 5'd3, 12'h01C);
        reg_op(1'b0, rv32_isa_pkg::F3_XOR, 5'd5, 5'd4, 5'd3);
        reg_op(1'b1, rv32_isa_pkg::F3_SR, 5'd6, 5'd5, 5'd1);
        reg_op(1'b0, rv32_isa_pkg::F3_ADD_SUB, 5'd6, 5'd6, 5'd6);
        imm_op(rv32_isa_pkg::F3_SLTU, 5'd7, 5'd6, 12'h7FF);
        reg_op(1'b0, rv32_isa_pkg::F3_OR, 5'd8, 5'd7, 5'd6);
        imm_op(rv32_isa_pkg::F3_AND, 5'd9, 5'd8, 12'hF0F);
        reg_op(1'b0, rv32_isa_pkg::F3_SLT, 5'd10, 5'd9, 5'd0);
        halt_instr();
        run_program(1'b0);
        compare_regs();
        report_test("forwarding_chain", e);
    endtask

    // Random instruction mix under a random global stall
    task automatic random_stall();
        int                  e;
        rv32_isa_pkg::word_t r;
        logic [2:0]          f3;
        logic [11:0]         imm;
        e = errors;
        new_program();
        for (int i = 1; i < 8; i++) begin
            r = $urandom;
            upper_imm(rv32_isa_pkg::reg_addr_t'(i), r[19:0]);
        end
        for (int n = 0; n < 24; n++) begin
            r   = $urandom;
            f3  = r[2:0];
            imm = r[31:20];
            if (r[12]) begin
                reg_op(r[13] && (f3 == rv32_isa_pkg::F3_ADD_SUB || f3 == rv32_isa_pkg::F3_SR),
                       f3, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]});
            end else begin
                // Legal shift immediates only
                if (f3 == rv32_isa_pkg::F3_SLL || f3 == rv32_isa_pkg::F3_SR) begin
                    imm = imm & 12'h41F;
                end
                imm_op(f3, {2'b00, r[5:3]}, {2'b00, r[8:6]}, imm);
            end
        end
        halt_instr();
        run_program(1'b1);
        compare_regs();
        report_test("random_stall", e);
    endtask

    task automatic halt_and_reset();
        int e;
        e = errors;
        new_program();
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h00B);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd2, 5'd1, 12'h001);
        halt_instr();
        // Past the halt, must never retire
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'h063);
        imm_op(rv32_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h007);
        upper_imm(5'd4, 20'hDEAD0);
        run_program(1'b0);
        repeat (6) begin
            @(negedge clk);
            check_word("instr_addr_o", halt_addr, instr_addr);
            check_flag("halted_o", 1'b1, halted);
        end
        compare_regs();
        // Empty ROM, so the core only runs NOPs after reset
        new_program();
        reset_core();
        @(negedge clk);
        check_flag("halted_o", 1'b0, halted);
        compare_regs();
        report_test("halt_and_reset", e);
    endtask

    initial begin
        rst          = 1'b1;
        stall        = 1'b0;
        dbg_addr     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        new_program();
        void'($urandom(32'h59d926fe));
        r_type_ops();
        imm_forms();
        forwarding_chain();
        random_stall();
        halt_and_reset();
        $display("Tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/rv32_isa_pkg.sv
source/core_pipe_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/pipeline_register.sv
source/execute_unit.sv
source/rv32_core.sv
tb/tb_rv32_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_rv32_core -o tb_rv32_core
if [ $? -ne 0 ]; then
    echo "Verilator build error"
    exit 1
fi

./obj_dir/tb_rv32_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
